// ==== logic/swarm_pkg.sv ====
package swarm_pkg;

   // ========================================================================
   // limits and scalar types
   // ========================================================================

   // largest supported entry-count exponent of the task send buffer.
   localparam int MAX_LOG_TSB_SIZE = 4;

   typedef logic [31:0]                 ts_t;
   typedef logic [31:0]                 locale_t;
   typedef logic [3:0]                  tile_id_t;
   typedef logic [MAX_LOG_TSB_SIZE-1:0] tsb_entry_id_t;
   typedef logic [7:0]                  epoch_t;
   typedef logic [5:0]                  tq_slot_t;
   typedef logic [4:0]                  cq_slice_slot_t;
   typedef logic [1:0]                  child_id_t;

   // ========================================================================
   // opcodes and register map
   // ========================================================================

   typedef enum logic [3:0] {
      TASK_NOP      = 4'd0,
      TASK_COMPUTE  = 4'd1,
      TASK_SPILL    = 4'd2,
      TASK_SPLITTER = 4'd3
   } task_type_e;

   typedef enum logic [7:0] {
      TSB_LOG_N_TILES = 8'h20,
      TSB_ENTRY_VALID = 8'h24
   } tsb_reg_addr_e;

   // ========================================================================
   // channel payloads
   // ========================================================================

   typedef struct packed {
      ts_t        ts;
      locale_t    locale;
      task_type_e ttype;
      logic [15:0] args;
   } task_t;

   typedef struct packed {
      task_t          task_data;
      logic           tied;
      cq_slice_slot_t cq_slot;
      child_id_t      child_id;
   } child_req_t;

   typedef struct packed {
      tsb_entry_id_t tsb_id;
      logic          abort;
      logic          tied;
   } retry_req_t;

   typedef struct packed {
      task_t         task_data;
      logic          tied;
      tile_id_t      dest_tile;
      tsb_entry_id_t tsb_id;
   } enq_req_t;

   typedef struct packed {
      logic          ack;
      tsb_entry_id_t tsb_id;
      epoch_t        epoch;
      tq_slot_t      tq_slot;
   } tile_resp_t;

   typedef struct packed {
      logic           ack;
      tsb_entry_id_t  tsb_slot;
      epoch_t         epoch;
      tq_slot_t       tq_slot;
      tile_id_t       tile_id;
      cq_slice_slot_t cq_slot;
      child_id_t      child_id;
   } child_resp_t;

   typedef struct packed {
      tsb_reg_addr_e waddr;
      logic [31:0]   wdata;
   } reg_wr_t;

   typedef struct packed {
      logic [31:0] rdata;
   } reg_rd_t;

endpackage

// ==== logic/lowbit.sv ====
module lowbit #(
   parameter int IN_WIDTH  = 8,
   parameter int OUT_WIDTH = 3
) (
   input  logic [IN_WIDTH-1:0]  in,
   output logic [OUT_WIDTH-1:0] out
);

   // scan from the top so that the lowest set bit is the last one to win.
   // an all-zero input leaves the index at zero.
   always_comb begin
      out = '0;
      for (int i = IN_WIDTH - 1; i >= 0; i--) begin
         if (in[i]) begin
            out = OUT_WIDTH'(i);
         end
      end
   end

endmodule

// ==== logic/tile_map.sv ====
module tile_map (
   input  swarm_pkg::locale_t  locale,
   input  logic [4:0]          n_tiles,
   output swarm_pkg::tile_id_t dest
);
   import swarm_pkg::*;

   // the low four locale bits address within a tile, so they are skipped.
   logic [26:0] loc_hi;

   assign loc_hi = locale[30:4];

   // constant divisors per tile count keep each modulo a small fixed circuit.
   always_comb begin
      case (n_tiles)
         5'd1:    dest = '0;
         5'd2:    dest = tile_id_t'(locale[4]);
         5'd3:    dest = tile_id_t'(loc_hi % 27'd3);
         5'd4:    dest = tile_id_t'(locale[5:4]);
         5'd5:    dest = tile_id_t'(loc_hi % 27'd5);
         5'd6:    dest = tile_id_t'(loc_hi % 27'd6);
         5'd7:    dest = tile_id_t'(loc_hi % 27'd7);
         5'd8:    dest = tile_id_t'(locale[6:4]);
         5'd9:    dest = tile_id_t'(loc_hi % 27'd9);
         5'd10:   dest = tile_id_t'(loc_hi % 27'd10);
         5'd11:   dest = tile_id_t'(loc_hi % 27'd11);
         5'd12:   dest = tile_id_t'(loc_hi % 27'd12);
         default: dest = locale[7:4];
      endcase
   end

endmodule

// ==== logic/tsb_lvt_scan.sv ====
module tsb_lvt_scan #(
   parameter int LOG_TSB_SIZE = 3
) (
   input  logic                       clk,
   input  logic                       rstn,
   input  logic [2**LOG_TSB_SIZE-1:0] entry_valid,
   input  swarm_pkg::ts_t             scan_ts,
   output logic [LOG_TSB_SIZE-1:0]    scan_idx,
   output swarm_pkg::ts_t             lvt
);
   import swarm_pkg::*;

   ts_t  rolling_min;
   logic seen_valid;
   logic cur_valid;

   assign cur_valid = entry_valid[scan_idx];

   // one entry per cycle. at index zero the minimum of the finished period
   // is published and a new period starts from entry zero.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         scan_idx    <= '0;
         rolling_min <= '1;
         seen_valid  <= 1'b0;
         lvt         <= '0;
      end else begin
         scan_idx <= scan_idx + 1'b1;
         if (scan_idx == '0) begin
            lvt         <= rolling_min;
            rolling_min <= cur_valid ? scan_ts : '1;
            seen_valid  <= cur_valid;
         end else begin
            if (cur_valid && (scan_ts < rolling_min)) begin
               rolling_min <= scan_ts;
            end
            seen_valid <= seen_valid | cur_valid;
         end
      end
   end

   // a period that saw no live entry has to publish the idle value.
   a_idle_lvt: assert property (@(posedge clk) disable iff (!rstn)
      (scan_idx == '0 && !seen_valid) |=> (lvt == '1));

endmodule

// ==== logic/tsb.sv ====
module tsb #(
   parameter int LOG_TSB_SIZE = 3,
   parameter int N_TILES      = 4
) (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   s_valid,
   output logic                   s_ready,
   input  swarm_pkg::child_req_t  s_data,
   input  logic                   retry_valid,
   output logic                   retry_ready,
   input  swarm_pkg::retry_req_t  retry_data,
   output logic                   enq_valid,
   input  logic                   enq_ready,
   output swarm_pkg::enq_req_t    enq_data,
   input  logic                   resp_in_valid,
   output logic                   resp_in_ready,
   input  swarm_pkg::tile_resp_t  resp_in_data,
   output logic                   resp_out_valid,
   input  logic                   resp_out_ready,
   output swarm_pkg::child_resp_t resp_out_data,
   input  logic                   reg_wvalid,
   input  swarm_pkg::reg_wr_t     reg_wdata,
   input  logic                   reg_arvalid,
   input  logic [7:0]             reg_araddr,
   output logic                   reg_rvalid,
   output swarm_pkg::reg_rd_t     reg_rdata,
   output logic                   almost_full,
   output logic                   empty,
   output swarm_pkg::ts_t         lvt
);
   import swarm_pkg::*;

   localparam int N_ENTRIES = 2 ** LOG_TSB_SIZE;
   localparam int CNT_W     = LOG_TSB_SIZE + 1;
   localparam logic [CNT_W-1:0] FULL_MARK = CNT_W'(N_ENTRIES - 4);

   if (LOG_TSB_SIZE < 2 || LOG_TSB_SIZE > MAX_LOG_TSB_SIZE) begin : g_bad_size
      $error("tsb: LOG_TSB_SIZE must lie between 2 and MAX_LOG_TSB_SIZE");
   end

   // ========================================================================
   // entry table
   // ========================================================================

   logic [N_ENTRIES-1:0]    entry_valid;
   task_t                   entry_task     [N_ENTRIES];
   logic                    entry_tied     [N_ENTRIES];
   tile_id_t                entry_tile     [N_ENTRIES];
   cq_slice_slot_t          entry_cq_slot  [N_ENTRIES];
   child_id_t               entry_child_id [N_ENTRIES];

   logic [LOG_TSB_SIZE-1:0] next_free;
   logic [LOG_TSB_SIZE-1:0] retry_idx;
   logic [LOG_TSB_SIZE-1:0] resp_idx;
   logic [LOG_TSB_SIZE-1:0] scan_idx;
   tile_id_t                map_dest;
   logic [4:0]              n_tiles;
   logic [CNT_W-1:0]        occupancy;

   logic enq_free;
   logic s_fire;
   logic retry_fire;
   logic retry_resend;
   logic retry_drop;
   logic resp_fire;
   logic resp_free;
   logic resp_tied;

   lowbit #(
      .IN_WIDTH  (N_ENTRIES),
      .OUT_WIDTH (LOG_TSB_SIZE)
   ) u_free_sel (
      .in  (~entry_valid),
      .out (next_free)
   );

   tile_map u_tile_map (
      .locale  (s_data.task_data.locale),
      .n_tiles (n_tiles),
      .dest    (map_dest)
   );

   tsb_lvt_scan #(
      .LOG_TSB_SIZE (LOG_TSB_SIZE)
   ) u_lvt_scan (
      .clk         (clk),
      .rstn        (rstn),
      .entry_valid (entry_valid),
      .scan_ts     (entry_task[scan_idx].ts),
      .scan_idx    (scan_idx),
      .lvt         (lvt)
   );

   assign retry_idx = retry_data.tsb_id[LOG_TSB_SIZE-1:0];
   assign resp_idx  = resp_in_data.tsb_id[LOG_TSB_SIZE-1:0];

   // new tasks win over retries. a retry still gets through while a child
   // waits on a full table, so aborts can drain it.
   assign enq_free      = !enq_valid || enq_ready;
   assign s_ready       = enq_free && !entry_valid[next_free];
   assign retry_ready   = enq_free && !(s_valid && s_ready);
   assign resp_in_ready = !resp_out_valid;

   assign s_fire       = s_valid && s_ready;
   assign retry_fire   = retry_valid && retry_ready;
   assign retry_resend = retry_fire && !retry_data.abort;
   assign retry_drop   = retry_fire && retry_data.abort;
   assign resp_fire    = resp_in_valid && resp_in_ready;
   assign resp_free    = resp_fire && resp_in_data.ack;
   assign resp_tied    = resp_fire && entry_tied[resp_idx];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         entry_valid <= '0;
      end else begin
         if (s_fire) begin
            entry_valid[next_free] <= 1'b1;
         end
         if (retry_drop) begin
            entry_valid[retry_idx] <= 1'b0;
         end
         if (resp_free) begin
            entry_valid[resp_idx] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         occupancy <= '0;
      end else begin
         occupancy <= occupancy + CNT_W'(s_fire) - CNT_W'(retry_drop) - CNT_W'(resp_free);
      end
   end

   assign almost_full = occupancy > FULL_MARK;
   assign empty       = entry_valid == '0;

   // ========================================================================
   // enqueue and child response registers
   // ========================================================================

   always_ff @(posedge clk) begin
      if (!rstn) begin
         enq_valid <= 1'b0;
      end else if (s_fire || retry_resend) begin
         enq_valid <= 1'b1;
      end else if (enq_valid && enq_ready) begin
         enq_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (s_fire) begin
         enq_data.task_data        <= s_data.task_data;
         enq_data.tied             <= s_data.tied;
         enq_data.dest_tile        <= map_dest;
         enq_data.tsb_id           <= tsb_entry_id_t'(next_free);
         entry_task[next_free]     <= s_data.task_data;
         entry_tied[next_free]     <= s_data.tied;
         entry_tile[next_free]     <= map_dest;
         entry_cq_slot[next_free]  <= s_data.cq_slot;
         entry_child_id[next_free] <= s_data.child_id;
      end else if (retry_resend) begin
         // the retry may change whether the task is tied.
         enq_data.task_data    <= entry_task[retry_idx];
         enq_data.tied         <= retry_data.tied;
         enq_data.dest_tile    <= entry_tile[retry_idx];
         enq_data.tsb_id       <= retry_data.tsb_id;
         entry_tied[retry_idx] <= retry_data.tied;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         resp_out_valid <= 1'b0;
      end else if (resp_tied) begin
         resp_out_valid <= 1'b1;
      end else if (resp_out_valid && resp_out_ready) begin
         resp_out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (resp_tied) begin
         resp_out_data.ack      <= resp_in_data.ack;
         resp_out_data.tsb_slot <= resp_in_data.tsb_id;
         resp_out_data.epoch    <= resp_in_data.epoch;
         resp_out_data.tq_slot  <= resp_in_data.tq_slot;
         resp_out_data.tile_id  <= entry_tile[resp_idx];
         resp_out_data.cq_slot  <= entry_cq_slot[resp_idx];
         resp_out_data.child_id <= entry_child_id[resp_idx];
      end
   end

   // ========================================================================
   // register bus
   // ========================================================================

   always_ff @(posedge clk) begin
      if (!rstn) begin
         n_tiles <= 5'(N_TILES);
      end else if (reg_wvalid && (reg_wdata.waddr == TSB_LOG_N_TILES)) begin
         n_tiles <= reg_wdata.wdata[4:0];
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_arvalid) begin
         case (reg_araddr)
            TSB_ENTRY_VALID: reg_rdata.rdata <= 32'(entry_valid);
            TSB_LOG_N_TILES: reg_rdata.rdata <= 32'(n_tiles);
            default:         reg_rdata.rdata <= '0;
         endcase
      end
   end

   // the free-slot finder must point at a free entry whenever one exists.
   a_alloc_free: assert property (@(posedge clk) disable iff (!rstn)
      !(&entry_valid) |-> !entry_valid[next_free]);

   a_one_source: assert property (@(posedge clk) disable iff (!rstn)
      !(s_fire && retry_fire));

   // the network and the child manager only ever refer to live entries.
   a_resp_live: assert property (@(posedge clk) disable iff (!rstn)
      resp_fire |-> entry_valid[resp_idx]);

   a_retry_live: assert property (@(posedge clk) disable iff (!rstn)
      retry_fire |-> entry_valid[retry_idx]);

endmodule

// ==== logic/task_unit.sv ====
module task_unit #(
   parameter int LOG_TSB_SIZE = 3,
   parameter int N_TILES      = 4
) (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   s_valid,
   output logic                   s_ready,
   input  swarm_pkg::child_req_t  s_data,
   input  logic                   retry_valid,
   output logic                   retry_ready,
   input  swarm_pkg::retry_req_t  retry_data,
   output logic                   enq_valid,
   input  logic                   enq_ready,
   output swarm_pkg::enq_req_t    enq_data,
   input  logic                   resp_in_valid,
   output logic                   resp_in_ready,
   input  swarm_pkg::tile_resp_t  resp_in_data,
   output logic                   resp_out_valid,
   input  logic                   resp_out_ready,
   output swarm_pkg::child_resp_t resp_out_data,
   input  logic                   reg_wvalid,
   input  swarm_pkg::reg_wr_t     reg_wdata,
   input  logic                   reg_arvalid,
   input  logic [7:0]             reg_araddr,
   output logic                   reg_rvalid,
   output swarm_pkg::reg_rd_t     reg_rdata,
   output logic                   almost_full,
   output logic                   empty,
   output swarm_pkg::ts_t         lvt
);

   // the send buffer is the whole tile-side task unit for now.
   tsb #(
      .LOG_TSB_SIZE (LOG_TSB_SIZE),
      .N_TILES      (N_TILES)
   ) u_tsb (
      .*
   );

endmodule

// ==== dv/tb_task_unit.sv ====
module tb_task_unit;
   timeunit 1ns;
   timeprecision 1ps;
   import swarm_pkg::*;

   parameter int SEED = 32'h2c71;

   localparam int LOG_TSB_SIZE      = 3;
   localparam int N_TILES           = 4;
   localparam int N_ENTRIES         = 2 ** LOG_TSB_SIZE;
   localparam int CLK_PERIOD        = 20;
   localparam int MAX_WAIT          = 50;
   localparam int N_TESTS           = 6;
   localparam int WORST_TEST_CYCLES = 1000;

   logic        clk;
   logic        rstn;
   logic        s_valid;
   logic        s_ready;
   child_req_t  s_data;
   logic        retry_valid;
   logic        retry_ready;
   retry_req_t  retry_data;
   logic        enq_valid;
   logic        enq_ready;
   enq_req_t    enq_data;
   logic        resp_in_valid;
   logic        resp_in_ready;
   tile_resp_t  resp_in_data;
   logic        resp_out_valid;
   logic        resp_out_ready;
   child_resp_t resp_out_data;
   logic        reg_wvalid;
   reg_wr_t     reg_wdata;
   logic        reg_arvalid;
   logic [7:0]  reg_araddr;
   logic        reg_rvalid;
   reg_rd_t     reg_rdata;
   logic        almost_full;
   logic        empty;
   ts_t         lvt;

   // mirror of the entry table, built only from the traffic sent to the DUT.
   logic [N_ENTRIES-1:0] model_valid;
   task_t                model_task  [N_ENTRIES];
   logic                 model_tied  [N_ENTRIES];
   tile_id_t             model_tile  [N_ENTRIES];
   cq_slice_slot_t       model_cq    [N_ENTRIES];
   child_id_t            model_child [N_ENTRIES];
   logic [4:0]           model_n_tiles;
   int                   seed;
   string                test_name;

   task_unit #(
      .LOG_TSB_SIZE (LOG_TSB_SIZE),
      .N_TILES      (N_TILES)
   ) dut (
      .*
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(N_TESTS * WORST_TEST_CYCLES * CLK_PERIOD);
      $display("watchdog expired before the tests finished");
      $display("*** TEST FAILED ***");
      $fatal(1, "watchdog timeout");
   end

   // ========================================================================
   // checking and reference rules
   // ========================================================================

   task automatic check_value(input string what, input logic [127:0] expected,
                              input logic [127:0] actual);
      if (actual !== expected) begin
         $display("Error: %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
         $display("*** TEST FAILED ***");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic wait_next_negedge(inout int waited, input string what);
      waited++;
      if (waited > MAX_WAIT) begin
         $display("%s: no %s within %0d cycles", test_name, what, MAX_WAIT);
         $display("*** TEST FAILED ***");
         $fatal(1, "handshake timeout");
      end else begin
         @(negedge clk);
      end
   endtask

   // locale bits 30:4 modulo the tile count, with a plain slice outside 1..12.
   function automatic tile_id_t expected_tile(locale_t loc, logic [4:0] n);
      logic [26:0] hi = loc[30:4];
      if (n >= 5'd1 && n <= 5'd12) begin
         return tile_id_t'(hi % 27'(n));
      end
      return loc[7:4];
   endfunction

   function automatic int lowest_free();
      for (int i = 0; i < N_ENTRIES; i++) begin
         if (!model_valid[i]) begin
            return i;
         end
      end
      return -1;
   endfunction

   function automatic child_req_t random_child(logic tied);
      child_req_t req;
      req.task_data.ts     = $random(seed);
      req.task_data.locale = $random(seed);
      req.task_data.ttype  = task_type_e'({2'b00, 2'($random(seed))});
      req.task_data.args   = 16'($random(seed));
      req.tied             = tied;
      req.cq_slot          = cq_slice_slot_t'($random(seed));
      req.child_id         = child_id_t'($random(seed));
      return req;
   endfunction

   function automatic enq_req_t expected_enq(child_req_t req, int id);
      enq_req_t e;
      e.task_data = req.task_data;
      e.tied      = req.tied;
      e.dest_tile = expected_tile(req.task_data.locale, model_n_tiles);
      e.tsb_id    = tsb_entry_id_t'(id);
      return e;
   endfunction

   function automatic child_resp_t expected_resp(tile_resp_t r, int id);
      child_resp_t c;
      c.ack      = r.ack;
      c.tsb_slot = r.tsb_id;
      c.epoch    = r.epoch;
      c.tq_slot  = r.tq_slot;
      c.tile_id  = model_tile[id];
      c.cq_slot  = model_cq[id];
      c.child_id = model_child[id];
      return c;
   endfunction

   function automatic tile_resp_t make_resp(int id, logic ack);
      tile_resp_t r;
      r.ack     = ack;
      r.tsb_id  = tsb_entry_id_t'(id);
      r.epoch   = epoch_t'($random(seed));
      r.tq_slot = tq_slot_t'($random(seed));
      return r;
   endfunction

   task automatic record_child(input child_req_t req, input int id);
      model_valid[id] = 1'b1;
      model_task[id]  = req.task_data;
      model_tied[id]  = req.tied;
      model_tile[id]  = expected_tile(req.task_data.locale, model_n_tiles);
      model_cq[id]    = req.cq_slot;
      model_child[id] = req.child_id;
   endtask

   // ========================================================================
   // channel drivers
   // ========================================================================

   task automatic offer_child(input child_req_t req);
      @(posedge clk);
      s_valid <= 1'b1;
      s_data  <= req;
   endtask

   task automatic finish_child();
      int waited = 0;
      @(negedge clk);
      while (!s_ready) begin
         wait_next_negedge(waited, "s_ready");
      end
      @(posedge clk);
      s_valid <= 1'b0;
   endtask

   task automatic expect_enq(input enq_req_t exp);
      int waited = 0;
      @(negedge clk);
      while (!enq_valid) begin
         wait_next_negedge(waited, "enq_valid");
      end
      check_value("enq_data", 128'(exp), 128'(enq_data));
      @(posedge clk);
   endtask

   task automatic push_child(input child_req_t req, output int id);
      enq_req_t exp;
      id  = lowest_free();
      exp = expected_enq(req, id);
      offer_child(req);
      finish_child();
      expect_enq(exp);
      record_child(req, id);
   endtask

   task automatic send_retry(input retry_req_t rr);
      int waited = 0;
      @(posedge clk);
      retry_valid <= 1'b1;
      retry_data  <= rr;
      @(negedge clk);
      while (!retry_ready) begin
         wait_next_negedge(waited, "retry_ready");
      end
      @(posedge clk);
      retry_valid <= 1'b0;
   endtask

   task automatic send_resp(input tile_resp_t r);
      int waited = 0;
      @(posedge clk);
      resp_in_valid <= 1'b1;
      resp_in_data  <= r;
      @(negedge clk);
      while (!resp_in_ready) begin
         wait_next_negedge(waited, "resp_in_ready");
      end
      @(posedge clk);
      resp_in_valid <= 1'b0;
   endtask

   task automatic expect_resp_out(input child_resp_t exp);
      int waited = 0;
      @(negedge clk);
      while (!resp_out_valid) begin
         wait_next_negedge(waited, "resp_out_valid");
      end
      check_value("resp_out_data", 128'(exp), 128'(resp_out_data));
      @(posedge clk);
   endtask

   task automatic retire(input int id, input logic ack);
      tile_resp_t r = make_resp(id, ack);
      send_resp(r);
      if (model_tied[id]) begin
         expect_resp_out(expected_resp(r, id));
      end else begin
         repeat (2) begin
            @(negedge clk);
            check_value("untied resp_out_valid", 128'(0), 128'(resp_out_valid));
         end
      end
      if (ack) begin
         model_valid[id] = 1'b0;
      end
   endtask

   task automatic drain_all();
      for (int i = 0; i < N_ENTRIES; i++) begin
         if (model_valid[i]) begin
            retire(i, 1'b1);
         end
      end
   endtask

   task automatic set_tiles(input logic [4:0] n);
      reg_wr_t w;
      w.waddr = TSB_LOG_N_TILES;
      w.wdata = 32'(n);
      @(posedge clk);
      reg_wvalid <= 1'b1;
      reg_wdata  <= w;
      @(posedge clk);
      reg_wvalid <= 1'b0;
      model_n_tiles = n;
   endtask

   task automatic check_bitmap();
      @(posedge clk);
      reg_arvalid <= 1'b1;
      reg_araddr  <= TSB_ENTRY_VALID;
      @(posedge clk);
      reg_arvalid <= 1'b0;
      @(negedge clk);
      check_value("reg_rvalid", 128'(1), 128'(reg_rvalid));
      check_value("entry bitmap", 128'(model_valid), 128'(reg_rdata.rdata));
   endtask

   task automatic check_lvt();
      ts_t min_ts = '1;
      for (int i = 0; i < N_ENTRIES; i++) begin
         if (model_valid[i] && model_task[i].ts < min_ts) begin
            min_ts = model_task[i].ts;
         end
      end
      repeat (2 * N_ENTRIES + 2) @(posedge clk);
      @(negedge clk);
      check_value("lvt", 128'(min_ts), 128'(lvt));
   endtask

   // ========================================================================
   // directed tests
   // ========================================================================

   task automatic test_enqueue_mapping();
      int         id;
      logic [4:0] tiles [4] = '{5'd1, 5'd3, 5'd4, 5'd16};
      test_name = "enqueue_mapping";
      @(negedge clk);
      check_value("empty before traffic", 128'(1), 128'(empty));
      foreach (tiles[t]) begin
         set_tiles(tiles[t]);
         for (int k = 0; k < 4; k++) begin
            push_child(random_child(1'($random(seed))), id);
            @(negedge clk);
            check_value("empty with live entries", 128'(0), 128'(empty));
         end
         drain_all();
      end
   endtask

   task automatic test_backpressure();
      child_req_t a = random_child(1'b0);
      child_req_t b = random_child(1'b1);
      enq_req_t   exp_a;
      enq_req_t   exp_b;
      test_name = "backpressure";
      exp_a = expected_enq(a, lowest_free());
      @(posedge clk);
      enq_ready <= 1'b0;
      offer_child(a);
      finish_child();
      record_child(a, int'(exp_a.tsb_id));
      exp_b = expected_enq(b, lowest_free());
      offer_child(b);
      repeat (4) begin
         @(negedge clk);
         check_value("s_ready under stall", 128'(0), 128'(s_ready));
         check_value("enq_valid under stall", 128'(1), 128'(enq_valid));
         check_value("held enq_data", 128'(exp_a), 128'(enq_data));
      end
      @(posedge clk);
      enq_ready <= 1'b1;
      // the held request drains on the same edge that takes the next task.
      finish_child();
      expect_enq(exp_b);
      record_child(b, int'(exp_b.tsb_id));
      drain_all();
   endtask

   task automatic test_responses();
      int         id;
      tile_resp_t r;
      test_name = "responses";
      push_child(random_child(1'b1), id);
      retire(id, 1'b1);
      check_bitmap();
      push_child(random_child(1'b0), id);
      retire(id, 1'b1);
      check_bitmap();
      push_child(random_child(1'b1), id);
      r = make_resp(id, 1'b0);
      @(posedge clk);
      resp_out_ready <= 1'b0;
      send_resp(r);
      repeat (3) begin
         @(negedge clk);
         check_value("stalled resp_out_valid", 128'(1), 128'(resp_out_valid));
         check_value("stalled resp_in_ready", 128'(0), 128'(resp_in_ready));
      end
      @(posedge clk);
      resp_out_ready <= 1'b1;
      expect_resp_out(expected_resp(r, id));
      check_bitmap();
      drain_all();
   endtask

   task automatic test_retry();
      int         id;
      retry_req_t rr;
      enq_req_t   exp;
      test_name = "retry";
      push_child(random_child(1'b0), id);
      rr.tsb_id     = tsb_entry_id_t'(id);
      rr.abort      = 1'b0;
      rr.tied       = 1'b1;
      exp.task_data = model_task[id];
      exp.tied      = 1'b1;
      exp.dest_tile = model_tile[id];
      exp.tsb_id    = rr.tsb_id;
      send_retry(rr);
      expect_enq(exp);
      model_tied[id] = 1'b1;
      retire(id, 1'b1);
      push_child(random_child(1'b1), id);
      rr.tsb_id = tsb_entry_id_t'(id);
      rr.abort  = 1'b1;
      send_retry(rr);
      repeat (3) begin
         @(negedge clk);
         check_value("enq_valid after abort", 128'(0), 128'(enq_valid));
      end
      model_valid[id] = 1'b0;
      check_bitmap();
   endtask

   task automatic test_capacity();
      int id;
      test_name = "capacity";
      for (int i = 0; i < N_ENTRIES; i++) begin
         push_child(random_child(1'($random(seed))), id);
         @(negedge clk);
         check_value("almost_full", 128'(i + 1 > N_ENTRIES - 4), 128'(almost_full));
      end
      offer_child(random_child(1'b0));
      repeat (4) begin
         @(negedge clk);
         check_value("s_ready when full", 128'(0), 128'(s_ready));
      end
      @(posedge clk);
      s_valid <= 1'b0;
      drain_all();
      @(negedge clk);
      check_value("empty after drain", 128'(1), 128'(empty));
   endtask

   task automatic test_lvt();
      int id;
      test_name = "lvt";
      repeat (3) begin
         push_child(random_child(1'b0), id);
      end
      check_lvt();
      retire(id, 1'b1);
      check_lvt();
      drain_all();
      check_lvt();
   endtask

   initial begin
      seed           = SEED;
      test_name      = "reset";
      rstn           = 1'b0;
      s_valid        = 1'b0;
      s_data         = '0;
      retry_valid    = 1'b0;
      retry_data     = '0;
      enq_ready      = 1'b1;
      resp_in_valid  = 1'b0;
      resp_in_data   = '0;
      resp_out_ready = 1'b1;
      reg_wvalid     = 1'b0;
      reg_wdata      = '0;
      reg_arvalid    = 1'b0;
      reg_araddr     = '0;
      model_valid    = '0;
      model_n_tiles  = 5'(N_TILES);
      repeat (3) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);
      check_value("enq_valid", 128'(0), 128'(enq_valid));
      check_value("resp_out_valid", 128'(0), 128'(resp_out_valid));
      check_value("reg_rvalid", 128'(0), 128'(reg_rvalid));
      check_value("almost_full", 128'(0), 128'(almost_full));
      check_value("empty", 128'(1), 128'(empty));
      check_value("lvt", 128'(0), 128'(lvt));
      test_enqueue_mapping();
      test_backpressure();
      test_responses();
      test_retry();
      test_capacity();
      test_lvt();
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// ==== project.f ====
logic/swarm_pkg.sv
logic/lowbit.sv
logic/tile_map.sv
logic/tsb_lvt_scan.sv
logic/tsb.sv
logic/task_unit.sv
dv/tb_task_unit.sv

// ==== Makefile ====
# Verilator build and run of the task unit testbench.

TOP       ?= tb_task_unit
SEED      ?= 11377
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
